//--- hdl/census_counter.sv
`default_nettype none

`include "taint_consts.svh"

module census_counter (
    input  logic               pos_clk,
    input  logic               pos_arst,
    input  logic               scan_clear,
    input  logic               scan_step,
    input  logic               entry_hit,
    output taint_pkg::addr_t   scan_index,
    output logic               scan_last,
    output taint_pkg::count_t  census_count
);

    taint_pkg::addr_t  index_q;
    taint_pkg::count_t tally_q;

    // index wraps back to zero after the last entry
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            index_q <= '0;
            tally_q <= '0;
        end else if (scan_clear) begin
            index_q <= '0;
            tally_q <= '0;
        end else if (scan_step) begin
            index_q <= index_q + 1'b1;
            tally_q <= tally_q + taint_pkg::count_t'(entry_hit);
        end
    end

    assign scan_index   = index_q;
    assign scan_last    = (index_q == taint_pkg::addr_t'(`TAINT_DEPTH - 1));
    assign census_count = tally_q;

endmodule

`default_nettype wire

//--- hdl/census_fsm.sv
`default_nettype none

module census_fsm (
    input  logic pos_clk,
    input  logic pos_arst,
    input  logic census_start,
    input  logic scan_last,
    output logic scan_clear,
    output logic scan_step,
    output logic census_busy,
    output logic census_done
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_SCAN = 2'd1,
        ST_DONE = 2'd2
    } state_e;

    state_e state, state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (census_start) begin
                    state_next = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (scan_last) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // starts outside idle are dropped
    assign scan_clear  = (state == ST_IDLE) && census_start;
    assign scan_step   = (state == ST_SCAN);
    assign census_busy = (state == ST_SCAN);
    assign census_done = (state == ST_DONE);

endmodule

`default_nettype wire

//--- hdl/taint_alu.sv
`default_nettype none

module taint_alu (
    input  logic                 pos_clk,
    input  logic                 pos_arst,
    input  logic                 alu_valid,
    input  taint_pkg::alu_req_t  alu_req,
    output taint_pkg::tword_t    result,
    output logic                 result_valid
);

    taint_pkg::word_t av, at, bv, bt;
    taint_pkg::word_t y, yt;
    taint_pkg::word_t lo_sum, hi_sum;
    taint_pkg::word_t en_diff;
    taint_pkg::tword_t res_q;

    assign av = alu_req.a.value;
    assign at = alu_req.a.taint;
    assign bv = alu_req.b.value;
    assign bt = alu_req.b.taint;

    // operation value and its taint rule
    always_comb begin
        lo_sum = '0;
        hi_sum = '0;
        case (alu_req.op)
            taint_pkg::ALU_AND: begin
                y  = av & bv;
                yt = (at & bv) | (bt & av) | (at & bt);
            end
            taint_pkg::ALU_OR: begin
                y  = av | bv;
                yt = (at & ~bv) | (bt & ~av) | (at & bt);
            end
            taint_pkg::ALU_ADD: begin
                y      = av + bv;
                // tainted bits forced low, then forced high
                lo_sum = (av & ~at) + (bv & ~bt);
                hi_sum = (av | at) + (bv | bt);
                yt     = (lo_sum ^ hi_sum) | at | bt;
            end
            taint_pkg::ALU_SUB: begin
                y      = av - bv;
                lo_sum = (av & ~at) - (bv & ~bt);
                hi_sum = (av | at) - (bv | bt);
                yt     = (lo_sum ^ hi_sum) | at | bt;
            end
            default: begin
                // xor and unknown opcodes: any input taint spreads to all bits
                y  = av ^ bv;
                yt = (|{at, bt}) ? '1 : '0;
            end
        endcase
    end

    // enable is treated as always differing, so d ^ q leaks into the taint
    assign en_diff = y ^ res_q.value;

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res_q        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= alu_valid;
            if (alu_valid) begin
                res_q.value <= y;
                res_q.taint <= yt | (alu_req.en_taint ? en_diff : '0);
            end else if (alu_req.en_taint) begin
                res_q.taint <= res_q.taint | en_diff;
            end
        end
    end

    assign result = res_q;

endmodule

`default_nettype wire

//--- hdl/taint_consts.svh
`ifndef TAINT_CONSTS_SVH
`define TAINT_CONSTS_SVH

// width of a value word and of its taint shadow
`define TAINT_WORD_WIDTH 8

// shadow memory geometry
`define TAINT_ADDR_BITS 4
`define TAINT_DEPTH 16

// census tally must reach the full depth
`define TAINT_COUNT_BITS 5

`endif

//--- hdl/taint_mem.sv
`default_nettype none

`include "taint_consts.svh"

module taint_mem (
    input  logic                   pos_clk,
    input  logic                   pos_arst,
    input  logic                   wr_strobe,
    input  taint_pkg::wr_req_t     wr_req,
    input  logic                   rd_strobe,
    input  taint_pkg::rd_req_t     rd_req,
    output taint_pkg::word_t       rd_taint,
    output logic                   rd_valid,
    input  taint_pkg::addr_t       scan_index,
    input  taint_pkg::live_mask_t  live_mask,
    output logic                   entry_hit
);

    taint_pkg::word_t mem_taint [`TAINT_DEPTH];
    taint_pkg::word_t wr_entry;
    taint_pkg::word_t wr_addr_fill;
    taint_pkg::word_t rd_addr_fill;
    taint_pkg::word_t rd_next;
    taint_pkg::word_t rd_q;

    // a tainted address may land on any entry, so the whole word is tainted
    assign wr_addr_fill = wr_req.addr_taint ? '1 : '0;
    assign rd_addr_fill = rd_req.addr_taint ? '1 : '0;

    assign wr_entry = (wr_req.data_taint & wr_req.en_mask) | wr_addr_fill | wr_req.en_taint;

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < `TAINT_DEPTH; i++) begin
                mem_taint[i] <= '0;
            end
        end else if (wr_strobe) begin
            mem_taint[wr_req.addr] <= wr_entry;
        end
    end

    // tainted read enable poisons the whole read word
    assign rd_next = rd_req.en_taint ? '1 : (mem_taint[rd_req.addr] | rd_addr_fill);

    // old entry on a same-edge collision
    always_ff @(posedge pos_clk) begin
        if (rd_strobe) begin
            rd_q <= rd_next;
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_strobe;
        end
    end

    assign rd_taint = rd_q;

    // census probe, bitmap liveness
    assign entry_hit = (|mem_taint[scan_index]) & live_mask[scan_index];

endmodule

`default_nettype wire

//--- hdl/taint_pkg.sv
`default_nettype none

`include "taint_consts.svh"

package taint_pkg;

    typedef logic [`TAINT_WORD_WIDTH-1:0] word_t;
    typedef logic [`TAINT_ADDR_BITS-1:0] addr_t;
    typedef logic [`TAINT_COUNT_BITS-1:0] count_t;
    typedef logic [`TAINT_DEPTH-1:0] live_mask_t;

    // xor shares the encoding space with the default rule
    typedef enum logic [2:0] {
        ALU_AND = 3'd0,
        ALU_OR  = 3'd1,
        ALU_ADD = 3'd2,
        ALU_SUB = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // value travels with its shadow taint
    typedef struct packed {
        word_t value;
        word_t taint;
    } tword_t;

    typedef struct packed {
        alu_op_e op;
        tword_t  a;
        tword_t  b;
        logic    en_taint;
    } alu_req_t;

    typedef struct packed {
        addr_t addr;
        logic  addr_taint;
        word_t en_mask;
        word_t en_taint;
        word_t data_taint;
    } wr_req_t;

    typedef struct packed {
        addr_t addr;
        logic  addr_taint;
        logic  en_taint;
    } rd_req_t;

endpackage

`default_nettype wire

//--- hdl/taint_shadow_top.sv
`default_nettype none

module taint_shadow_top (
    input  logic                   pos_clk,
    input  logic                   pos_arst,
    input  logic                   alu_valid,
    input  taint_pkg::alu_req_t    alu_req,
    input  logic                   wr_strobe,
    input  taint_pkg::wr_req_t     wr_req,
    input  logic                   rd_strobe,
    input  taint_pkg::rd_req_t     rd_req,
    input  logic                   census_start,
    input  taint_pkg::live_mask_t  live_mask,
    output taint_pkg::tword_t      result,
    output logic                   result_valid,
    output taint_pkg::word_t       rd_taint,
    output logic                   rd_valid,
    output logic                   census_busy,
    output logic                   census_done,
    output taint_pkg::count_t      census_count
);

    taint_pkg::addr_t scan_index;
    logic scan_last;
    logic scan_clear;
    logic scan_step;
    logic entry_hit;

    taint_alu taint_alu_i (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .alu_valid    (alu_valid),
        .alu_req      (alu_req),
        .result       (result),
        .result_valid (result_valid)
    );

    taint_mem taint_mem_i (
        .pos_clk    (pos_clk),
        .pos_arst   (pos_arst),
        .wr_strobe  (wr_strobe),
        .wr_req     (wr_req),
        .rd_strobe  (rd_strobe),
        .rd_req     (rd_req),
        .rd_taint   (rd_taint),
        .rd_valid   (rd_valid),
        .scan_index (scan_index),
        .live_mask  (live_mask),
        .entry_hit  (entry_hit)
    );

    // census control and its scan datapath
    census_fsm census_fsm_i (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .census_start (census_start),
        .scan_last    (scan_last),
        .scan_clear   (scan_clear),
        .scan_step    (scan_step),
        .census_busy  (census_busy),
        .census_done  (census_done)
    );

    census_counter census_counter_i (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .scan_clear   (scan_clear),
        .scan_step    (scan_step),
        .entry_hit    (entry_hit),
        .scan_index   (scan_index),
        .scan_last    (scan_last),
        .census_count (census_count)
    );

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/taint_pkg.sv
hdl/taint_alu.sv
hdl/taint_mem.sv
hdl/census_fsm.sv
hdl/census_counter.sv
hdl/taint_shadow_top.sv
testbench/taint_shadow_chk.sv
testbench/taint_shadow_tb.sv

//--- testbench/taint_shadow_chk.sv
`default_nettype none

`include "taint_consts.svh"

module taint_shadow_chk (
    input logic              pos_clk,
    input logic              pos_arst,
    input logic              alu_valid,
    input logic              result_valid,
    input logic              rd_strobe,
    input logic              rd_valid,
    input logic              census_start,
    input logic              census_busy,
    input logic              census_done,
    input taint_pkg::count_t census_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions
    int err_cnt = 0;

    assert property (@(posedge pos_clk) disable iff (pos_arst)
        result_valid == $past(alu_valid))
        else begin
            $error("result_valid does not follow alu_valid by one cycle");
            err_cnt++;
        end

    assert property (@(posedge pos_clk) disable iff (pos_arst)
        rd_valid == $past(rd_strobe))
        else begin
            $error("rd_valid does not follow rd_strobe by one cycle");
            err_cnt++;
        end

    // idle means neither scanning nor showing done
    assert property (@(posedge pos_clk) disable iff (pos_arst)
        (census_start && !census_busy && !census_done) |-> ##(`TAINT_DEPTH + 1) census_done)
        else begin
            $error("census_done missing depth+1 cycles after an idle start");
            err_cnt++;
        end

    assert property (@(posedge pos_clk) disable iff (pos_arst)
        census_count <= `TAINT_DEPTH)
        else begin
            $error("census_count exceeds the memory depth");
            err_cnt++;
        end

endmodule

bind taint_shadow_top taint_shadow_chk taint_shadow_chk_i (.*);

`default_nettype wire

//--- testbench/taint_shadow_tb.sv
`default_nettype none

`include "taint_consts.svh"

module taint_shadow_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                  pos_clk, pos_arst;
    logic                  alu_valid, wr_strobe, rd_strobe, census_start;
    taint_pkg::alu_req_t   alu_req;
    taint_pkg::wr_req_t    wr_req;
    taint_pkg::rd_req_t    rd_req;
    taint_pkg::live_mask_t live_mask;
    taint_pkg::tword_t     result;
    logic                  result_valid, rd_valid, census_busy, census_done;
    taint_pkg::word_t      rd_taint;
    taint_pkg::count_t     census_count;

    logic [31:0] lfsr;
    int          mismatch_cnt;
    int          failure_cnt;

    // reference model state
    taint_pkg::tword_t ref_reg;
    taint_pkg::word_t  ref_rd;
    taint_pkg::word_t  ref_mem [`TAINT_DEPTH];

    taint_shadow_top taint_shadow_top_i (.*);

    initial begin
        pos_clk = 1'b0;
        forever #2 pos_clk = ~pos_clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic taint_pkg::word_t take_bits(input int n);
        taint_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[`TAINT_WORD_WIDTH-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic taint_pkg::tword_t alu_ref(input taint_pkg::alu_req_t r);
        taint_pkg::tword_t o;
        taint_pkg::word_t lo, hi;
        o.value = r.a.value ^ r.b.value;
        o.taint = ((r.a.taint | r.b.taint) != '0) ? '1 : '0;
        case (r.op)
            taint_pkg::ALU_AND: begin
                o.value = r.a.value & r.b.value;
                o.taint = (r.a.taint & (r.b.value | r.b.taint)) | (r.b.taint & r.a.value);
            end
            taint_pkg::ALU_OR: begin
                o.value = r.a.value | r.b.value;
                o.taint = (r.a.taint & (~r.b.value | r.b.taint)) | (r.b.taint & ~r.a.value);
            end
            taint_pkg::ALU_ADD, taint_pkg::ALU_SUB: begin
                // every tainted bit pinned low, then pinned high
                lo = (r.op == taint_pkg::ALU_ADD) ?
                     (r.a.value & ~r.a.taint) + (r.b.value & ~r.b.taint) :
                     (r.a.value & ~r.a.taint) - (r.b.value & ~r.b.taint);
                hi = (r.op == taint_pkg::ALU_ADD) ?
                     (r.a.value | r.a.taint) + (r.b.value | r.b.taint) :
                     (r.a.value | r.a.taint) - (r.b.value | r.b.taint);
                o.value = (r.op == taint_pkg::ALU_ADD) ? r.a.value + r.b.value :
                                                         r.a.value - r.b.value;
                o.taint = (lo ^ hi) | r.a.taint | r.b.taint;
            end
            default: ;
        endcase
        return o;
    endfunction

    function automatic taint_pkg::tword_t reg_ref(input taint_pkg::tword_t q,
                                                  input taint_pkg::tword_t d,
                                                  input logic valid, input logic en);
        taint_pkg::tword_t n;
        n = q;
        if (valid) begin
            n.value = d.value;
            n.taint = d.taint | (en ? (d.value ^ q.value) : '0);
        end else if (en) begin
            n.taint = q.taint | d.value ^ q.value;
        end
        return n;
    endfunction

    function automatic taint_pkg::word_t wr_ref(input taint_pkg::wr_req_t w);
        return (w.addr_taint ? '1 : (w.data_taint & w.en_mask)) | w.en_taint;
    endfunction

    function automatic taint_pkg::word_t rd_ref(input taint_pkg::word_t entry,
                                                input taint_pkg::rd_req_t r);
        return (r.en_taint || r.addr_taint) ? '1 : entry;
    endfunction

    function automatic taint_pkg::count_t census_ref(input taint_pkg::live_mask_t mask);
        taint_pkg::count_t n;
        n = '0;
        for (int i = 0; i < `TAINT_DEPTH; i++) begin
            if (mask[i] && ref_mem[i] != '0)
                n = n + 1'b1;
        end
        return n;
    endfunction

    function automatic taint_pkg::alu_req_t rand_alu(input logic [2:0] op, input logic en);
        taint_pkg::alu_req_t r;
        r.op = taint_pkg::alu_op_e'(op);
        r.a.value = take_bits(8);
        r.a.taint = take_bits(8) & take_bits(8);
        r.b.value = take_bits(8);
        r.b.taint = take_bits(8) & take_bits(8);
        r.en_taint = en;
        return r;
    endfunction

    function automatic taint_pkg::wr_req_t rand_wr(input taint_pkg::addr_t addr);
        taint_pkg::wr_req_t w;
        w.addr = addr;
        w.addr_taint = (take_bits(3) == '0);
        w.en_mask = take_bits(8);
        w.en_taint = take_bits(8) & take_bits(8) & take_bits(8);
        w.data_taint = take_bits(8) & take_bits(8);
        return w;
    endfunction

    task automatic check_tword(input taint_pkg::tword_t got, input taint_pkg::tword_t exp,
                               input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %h/%h expected %h/%h", $time, what,
                     got.value, got.taint, exp.value, exp.taint);
        end
    endtask

    task automatic check_word(input taint_pkg::word_t got, input taint_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input taint_pkg::count_t got, input taint_pkg::count_t exp,
                               input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle();
        @(posedge pos_clk);
        alu_valid <= 1'b0;
        alu_req.en_taint <= 1'b0;
        wr_strobe <= 1'b0;
        rd_strobe <= 1'b0;
        census_start <= 1'b0;
    endtask

    task automatic run_census(input taint_pkg::live_mask_t mask, input logic extra_start);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        @(posedge pos_clk);
        live_mask <= mask;
        census_start <= 1'b1;
        @(posedge pos_clk);
        census_start <= 1'b0;
        // start sampled on this edge, done due on the depth+1-th negedge after it
        while (!seen && cycles < 4 * `TAINT_DEPTH) begin
            @(negedge pos_clk);
            cycles++;
            seen = census_done;
            // busy for the whole scan, low once done shows
            if (census_busy !== !seen) begin
                mismatch_cnt++;
                $display("MISMATCH at %0t: census_busy %b in scan cycle %0d", $time,
                         census_busy, cycles);
            end
            if (!seen && extra_start && (cycles == 3 || cycles == 4)) begin
                @(posedge pos_clk);
                census_start <= (cycles == 3);
            end
        end
        if (!seen) begin
            failure_cnt++;
            $display("census_done did not arrive within %0d cycles at %0t", cycles, $time);
        end else if (cycles != `TAINT_DEPTH + 1) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: census_done after %0d cycles expected %0d", $time,
                     cycles, `TAINT_DEPTH + 1);
        end
    endtask

    // compare what the last edge produced, then step the model over the next edge
    always @(negedge pos_clk) begin
        if (pos_arst) begin
            ref_reg = '0;
            for (int i = 0; i < `TAINT_DEPTH; i++)
                ref_mem[i] = '0;
        end else begin
            check_tword(result, ref_reg, "alu result");
            if (rd_valid)
                check_word(rd_taint, ref_rd, "read taint");
            if (census_done)
                check_count(census_count, census_ref(live_mask), "census count");
            ref_reg = reg_ref(ref_reg, alu_ref(alu_req), alu_valid, alu_req.en_taint);
            if (rd_strobe)
                ref_rd = rd_ref(ref_mem[rd_req.addr], rd_req);
            if (wr_strobe)
                ref_mem[wr_req.addr] = wr_ref(wr_req);
        end
    end

    initial begin
        lfsr = 32'h8265;
        mismatch_cnt = 0;
        failure_cnt = 0;
        pos_arst = 1'b1;
        alu_valid = 1'b0;
        alu_req = '0;
        wr_strobe = 1'b0;
        wr_req = '0;
        rd_strobe = 1'b0;
        rd_req = '0;
        census_start = 1'b0;
        live_mask = '0;
        repeat (8) @(posedge pos_clk);
        pos_arst <= 1'b0;
        @(negedge pos_clk);
        if (result_valid || rd_valid || census_busy || census_done) begin
            failure_cnt++;
            $display("control outputs not low after reset at %0t", $time);
        end
        run_census('1, 1'b0);
        // every opcode in turn, a few with the enable taint set
        for (int k = 0; k < 200; k++) begin
            @(posedge pos_clk);
            alu_valid <= 1'b1;
            alu_req <= rand_alu(3'(k % 5), (k % 7) == 0);
        end
        // enable taint mostly without valid, differences pile up in the taint
        for (int k = 0; k < 24; k++) begin
            @(posedge pos_clk);
            alu_valid <= (k % 6) == 0;
            alu_req <= rand_alu(3'(take_bits(8) % 5), 1'b1);
        end
        drive_idle();
        for (int k = 0; k < 48; k++) begin
            @(posedge pos_clk);
            wr_strobe <= 1'b1;
            wr_req <= rand_wr(taint_pkg::addr_t'(k));
        end
        drive_idle();
        // last reads carry a tainted enable
        for (int k = 0; k < 32; k++) begin
            @(posedge pos_clk);
            rd_strobe <= 1'b1;
            rd_req.addr <= taint_pkg::addr_t'(k);
            rd_req.addr_taint <= (take_bits(2) == '0);
            rd_req.en_taint <= (k >= 24);
        end
        drive_idle();
        run_census({take_bits(8), take_bits(8)}, 1'b1);
        run_census({take_bits(8), take_bits(8)}, 1'b0);
        drive_idle();
        @(negedge pos_clk);
        $display("error counts: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_cnt, failure_cnt, taint_shadow_top_i.taint_shadow_chk_i.err_cnt);
        if (mismatch_cnt == 0 && failure_cnt == 0 &&
            taint_shadow_top_i.taint_shadow_chk_i.err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
